/* list.f */
rtl/dist_pkg.sv
rtl/dist_switch_1x2.sv
rtl/dist_tree_level.sv
rtl/dist_cfg_apb.sv
rtl/dist_tree_top.sv
tests/dist_tree_props.sv
tests/dist_tree_tb.sv

/* rtl/dist_cfg_apb.sv */
`timescale 1ns/100ps

module dist_cfg_apb
(
	input  logic i_clk,
	input  logic i_rst_n,

	// apb3 slave
	input  logic                                i_psel,
	input  logic                                i_penable,
	input  logic                                i_pwrite,
	input  logic [dist_pkg::APB_ADDR_WIDTH-1:0] i_paddr,
	input  logic [31:0]                         i_pwdata,
	output logic [31:0]                         o_prdata,
	output logic                                o_pready,
	output logic                                o_pslverr,

	// live configuration to the tree
	output logic [dist_pkg::CFG_WIDTH-1:0]      o_cfg,
	output logic                                o_en
);

	////////////////////////////////////////
	// address decode
	////////////////////////////////////////

	logic access;
	logic hit_cmd;
	logic hit_ctrl;
	logic mapped;

	// second phase of a transfer
	assign access = i_psel & i_penable;

	// register hits, full address compare
	assign hit_cmd  = (i_paddr == dist_pkg::ADDR_CMD);
	assign hit_ctrl = (i_paddr == dist_pkg::ADDR_CTRL);
	assign mapped   = hit_cmd | hit_ctrl;

	////////////////////////////////////////
	// registers
	////////////////////////////////////////

	logic wr_cmd;
	logic wr_ctrl;

	// writes land at the end of the access phase
	assign wr_cmd  = access & i_pwrite & hit_cmd;
	assign wr_ctrl = access & i_pwrite & hit_ctrl;

	// command word, all switches off after reset
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_cfg <= '0;
		end
		else if (wr_cmd)
		begin
			// upper bits of the bus dropped
			o_cfg <= i_pwdata[dist_pkg::CFG_WIDTH-1:0];
		end
	end

	// global enable
	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_en <= 1'b0;
		end
		else if (wr_ctrl)
		begin
			o_en <= i_pwdata[0];
		end
	end

	////////////////////////////////////////
	// read path and response
	////////////////////////////////////////

	// read mux, zero extended, unmapped reads zero
	always_comb
	begin
		o_prdata = '0;
		if (hit_cmd)
		begin
			o_prdata[dist_pkg::CFG_WIDTH-1:0] = o_cfg;
		end
		else if (hit_ctrl)
		begin
			o_prdata[0] = o_en;
		end
	end

	// no wait states
	assign o_pready = 1'b1;

	// error only in the access phase of an unmapped address
	assign o_pslverr = access & ~mapped;

endmodule

/* rtl/dist_pkg.sv */
package dist_pkg;

	////////////////////////////////////////
	// tree sizes
	////////////////////////////////////////

	// width of one payload word
	localparam int DATA_WIDTH = 32;

	// root to leaf depth, one pipeline stage per level
	localparam int NUM_LEVELS = 3;

	// a full binary tree doubles per level
	localparam int NUM_LEAVES = 1 << NUM_LEVELS;

	// one switch per inner node
	localparam int NUM_SWITCHES = NUM_LEAVES - 1;

	// bits per switch command
	localparam int CMD_WIDTH = 2;

	// full command word, root in the lowest bits
	localparam int CFG_WIDTH = NUM_SWITCHES * CMD_WIDTH;

	////////////////////////////////////////
	// switch commands
	////////////////////////////////////////

	// bit 0 selects the low branch, bit 1 the high branch
	typedef enum logic [CMD_WIDTH-1:0]
	{
		CMD_NONE = 2'b00,
		CMD_LOW  = 2'b01,
		CMD_HIGH = 2'b10,
		CMD_DUP  = 2'b11
	} switch_cmd_e;

	////////////////////////////////////////
	// apb register map
	////////////////////////////////////////

	localparam int APB_ADDR_WIDTH = 4;

	// command word, 14 bits used
	localparam logic [APB_ADDR_WIDTH-1:0] ADDR_CMD = 4'h0;
	// control, bit 0 is the global enable
	localparam logic [APB_ADDR_WIDTH-1:0] ADDR_CTRL = 4'h4;

endpackage

/* rtl/dist_switch_1x2.sv */
`timescale 1ns/100ps

module dist_switch_1x2
(
	// incoming word from the parent node
	input  logic                                     i_valid,
	input  logic [dist_pkg::DATA_WIDTH-1:0]          i_data,
	// routing command for this node
	input  dist_pkg::switch_cmd_e                    i_cmd,
	// index 0 is the low branch, index 1 the high branch
	output logic [1:0]                               o_valid,
	output logic [1:0][dist_pkg::DATA_WIDTH-1:0]     o_data
);

	////////////////////////////////////////
	// branch select
	////////////////////////////////////////

	always_comb
	begin
		// default is no branch, zero payload
		o_valid = 2'b00;
		o_data  = '0;

		// nothing leaves an idle switch
		if (i_valid)
		begin
			case (i_cmd)
				dist_pkg::CMD_NONE:
				begin
					// word dropped here
					o_valid = 2'b00;
				end
				dist_pkg::CMD_LOW:
				begin
					// low branch only
					o_valid   = 2'b01;
					o_data[0] = i_data;
				end
				dist_pkg::CMD_HIGH:
				begin
					// high branch only
					o_valid   = 2'b10;
					o_data[1] = i_data;
				end
				dist_pkg::CMD_DUP:
				begin
					// copy to both children
					o_valid   = 2'b11;
					o_data[0] = i_data;
					o_data[1] = i_data;
				end
				default:
				begin
					// unknown command acts as none
					o_valid = 2'b00;
				end
			endcase
		end
	end

endmodule

/* rtl/dist_tree_level.sv */
`timescale 1ns/100ps

module dist_tree_level
#(
	// 0 is the root level
	parameter int LEVEL = 0
)
(
	input  logic i_clk,
	input  logic i_rst_n,

	// one word per switch of this level
	input  logic [(1<<LEVEL)-1:0]                               i_valid,
	input  logic [(1<<LEVEL)-1:0][dist_pkg::DATA_WIDTH-1:0]     i_data,
	// command bits for this level and all deeper ones
	input  logic [dist_pkg::CMD_WIDTH*((1<<dist_pkg::NUM_LEVELS)-(1<<LEVEL))-1:0] i_cfg,

	// two outputs per switch, registered
	output logic [(1<<(LEVEL+1))-1:0]                           o_valid,
	output logic [(1<<(LEVEL+1))-1:0][dist_pkg::DATA_WIDTH-1:0] o_data,
	// deeper command bits, at least 1 bit wide
	output logic [((LEVEL+1 < dist_pkg::NUM_LEVELS) ?
		dist_pkg::CMD_WIDTH*((1<<dist_pkg::NUM_LEVELS)-(1<<(LEVEL+1))) : 1)-1:0] o_cfg
);

	// switches in this level
	localparam int NUM_SW = 1 << LEVEL;
	// command bits owned by this level
	localparam int CFG_OWN_W = dist_pkg::CMD_WIDTH * NUM_SW;
	// command bits handed down, zero at the last level
	localparam int CFG_REM_W = dist_pkg::CMD_WIDTH * ((1 << dist_pkg::NUM_LEVELS) - (1 << LEVEL))
		- CFG_OWN_W;

	////////////////////////////////////////
	// switches
	////////////////////////////////////////

	dist_pkg::switch_cmd_e                        sw_cmd [NUM_SW];
	logic [2*NUM_SW-1:0]                          sw_valid;
	logic [2*NUM_SW-1:0][dist_pkg::DATA_WIDTH-1:0] sw_data;

	for (genvar j = 0; j < NUM_SW; j++)
	begin : g_sw
		// switch j owns the j-th slice from the low end
		assign sw_cmd[j] = dist_pkg::switch_cmd_e'(
			i_cfg[j*dist_pkg::CMD_WIDTH +: dist_pkg::CMD_WIDTH]);

		// switch j feeds outputs 2j and 2j+1
		dist_switch_1x2 sw_i
		(
			.i_valid (i_valid[j]),
			.i_data  (i_data[j]),
			.i_cmd   (sw_cmd[j]),
			.o_valid (sw_valid[2*j +: 2]),
			.o_data  (sw_data[2*j +: 2])
		);
	end

	////////////////////////////////////////
	// stage registers
	////////////////////////////////////////

	always_ff @(posedge i_clk or negedge i_rst_n)
	begin
		if (!i_rst_n)
		begin
			o_valid <= '0;
			o_data  <= '0;
		end
		else
		begin
			o_valid <= sw_valid;
			// invalid outputs always carry zero
			for (int k = 0; k < 2*NUM_SW; k++)
			begin
				o_data[k] <= sw_valid[k] ? sw_data[k] : '0;
			end
		end
	end

	// remaining commands travel with the data
	if (CFG_REM_W > 0)
	begin : g_cfg
		always_ff @(posedge i_clk or negedge i_rst_n)
		begin
			if (!i_rst_n)
				o_cfg <= '0;
			else
				o_cfg <= i_cfg[CFG_OWN_W +: CFG_REM_W];
		end
	end
	else
	begin : g_no_cfg
		// last level, nothing left to forward
		assign o_cfg = '0;
	end

endmodule

/* rtl/dist_tree_top.sv */
`timescale 1ns/100ps

module dist_tree_top
(
	input  logic i_clk,
	input  logic i_rst_n,

	// apb configuration port
	input  logic                                i_psel,
	input  logic                                i_penable,
	input  logic                                i_pwrite,
	input  logic [dist_pkg::APB_ADDR_WIDTH-1:0] i_paddr,
	input  logic [31:0]                         i_pwdata,
	output logic [31:0]                         o_prdata,
	output logic                                o_pready,
	output logic                                o_pslverr,

	// root input, one word per cycle
	input  logic                                i_valid,
	input  logic [dist_pkg::DATA_WIDTH-1:0]     i_data,

	// leaves, three cycles after entry
	output logic [dist_pkg::NUM_LEAVES-1:0]                           o_leaf_valid,
	output logic [dist_pkg::NUM_LEAVES-1:0][dist_pkg::DATA_WIDTH-1:0] o_leaf_data
);

	////////////////////////////////////////
	// configuration
	////////////////////////////////////////

	logic [dist_pkg::CFG_WIDTH-1:0] cfg;
	logic                           en;

	dist_cfg_apb cfg_i
	(
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.o_cfg     (cfg),
		.o_en      (en)
	);

	////////////////////////////////////////
	// tree
	////////////////////////////////////////

	// input dropped while disabled
	logic root_valid;
	assign root_valid = i_valid & en;

	// level 0 to level 1, root command consumed
	logic [1:0]                                        l1_valid;
	logic [1:0][dist_pkg::DATA_WIDTH-1:0]              l1_data;
	logic [dist_pkg::CFG_WIDTH-dist_pkg::CMD_WIDTH-1:0] l1_cfg;

	// level 1 to level 2, only the leaf switch commands left
	logic [3:0]                                          l2_valid;
	logic [3:0][dist_pkg::DATA_WIDTH-1:0]                l2_data;
	logic [dist_pkg::CFG_WIDTH-3*dist_pkg::CMD_WIDTH-1:0] l2_cfg;

	// live command word is captured with the word at entry
	dist_tree_level #(.LEVEL(0)) lvl0_i
	(
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (root_valid),
		.i_data  (i_data),
		.i_cfg   (cfg),
		.o_valid (l1_valid),
		.o_data  (l1_data),
		.o_cfg   (l1_cfg)
	);

	dist_tree_level #(.LEVEL(1)) lvl1_i
	(
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (l1_valid),
		.i_data  (l1_data),
		.i_cfg   (l1_cfg),
		.o_valid (l2_valid),
		.o_data  (l2_data),
		.o_cfg   (l2_cfg)
	);

	// last level, no command bits left to forward
	dist_tree_level #(.LEVEL(2)) lvl2_i
	(
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (l2_valid),
		.i_data  (l2_data),
		.i_cfg   (l2_cfg),
		.o_valid (o_leaf_valid),
		.o_data  (o_leaf_data),
		.o_cfg   ()
	);

endmodule

/* tests/dist_tree_props.sv */
`timescale 1ns/100ps

module dist_tree_props
(
	input logic                                i_clk,
	input logic                                i_rst_n,
	input logic                                i_psel,
	input logic                                i_penable,
	input logic [dist_pkg::APB_ADDR_WIDTH-1:0] i_paddr,
	input logic                                i_pready,
	input logic                                i_pslverr,
	input logic                                i_valid,
	input logic                                i_en,
	input logic [dist_pkg::NUM_LEAVES-1:0]     i_leaf_valid
);

	// failed property count
	int fail_count = 0;

	// access phase to an address outside the register map
	logic bad_access;
	assign bad_access = i_psel && i_penable && (i_paddr != dist_pkg::ADDR_CMD)
		&& (i_paddr != dist_pkg::ADDR_CTRL);

	////////////////////////////////////////
	// tree
	////////////////////////////////////////

	// nothing left in the stages on the first edge out of reset
	a_reset_quiet: assert property (@(posedge i_clk) $rose(i_rst_n) |-> i_leaf_valid == '0)
	else
	begin
		fail_count++;
		$error("leaf valid set right after reset release");
	end

	// every leaf word traces back to an enabled input three edges before
	a_latency: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(|i_leaf_valid) |-> $past(i_valid && i_en, dist_pkg::NUM_LEVELS))
	else
	begin
		fail_count++;
		$error("leaf valid without an accepted input three cycles earlier");
	end

	////////////////////////////////////////
	// apb response
	////////////////////////////////////////

	a_no_wait: assert property (@(posedge i_clk) disable iff (!i_rst_n) i_pready)
	else
	begin
		fail_count++;
		$error("pready dropped");
	end

	// slave error exactly on unmapped access phases
	a_err_only_unmapped: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_pslverr |-> bad_access)
	else
	begin
		fail_count++;
		$error("pslverr outside an unmapped access phase");
	end

	a_err_on_unmapped: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		bad_access |-> i_pslverr)
	else
	begin
		fail_count++;
		$error("unmapped access phase without pslverr");
	end

endmodule

bind dist_tree_top dist_tree_props props_i
(
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_psel       (i_psel),
	.i_penable    (i_penable),
	.i_paddr      (i_paddr),
	.i_pready     (o_pready),
	.i_pslverr    (o_pslverr),
	.i_valid      (i_valid),
	.i_en         (en),
	.i_leaf_valid (o_leaf_valid)
);

/* tests/dist_tree_tb.sv */
`timescale 1ns/100ps

module dist_tree_tb;

	logic i_clk;
	logic i_rst_n;
	logic i_psel;
	logic i_penable;
	logic i_pwrite;
	logic [dist_pkg::APB_ADDR_WIDTH-1:0] i_paddr;
	logic [31:0] i_pwdata;
	logic [31:0] o_prdata;
	logic o_pready;
	logic o_pslverr;
	logic i_valid;
	logic [dist_pkg::DATA_WIDTH-1:0] i_data;
	logic [dist_pkg::NUM_LEAVES-1:0] o_leaf_valid;
	logic [dist_pkg::NUM_LEAVES-1:0][dist_pkg::DATA_WIDTH-1:0] o_leaf_data;

	// register contents as software last wrote them
	logic [dist_pkg::CFG_WIDTH-1:0] sw_cmd;
	logic sw_en;
	// {accepted, command word, data} per edge, oldest first
	logic [dist_pkg::CFG_WIDTH+dist_pkg::DATA_WIDTH:0] inflight [$];
	int max_wait = 1000;
	int errors;
	int checks;
	int tests;

	dist_tree_top dut_i (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////

	// leaf k needs bit k[2-l] of its level-l switch command on every level
	function automatic logic leaf_hit(logic [dist_pkg::CFG_WIDTH-1:0] cmd, int k);
		logic hit;
		int sw;
		hit = 1'b1;
		for (int l = 0; l < dist_pkg::NUM_LEVELS; l++)
		begin
			sw = k >> (dist_pkg::NUM_LEVELS - l);
			hit = hit & cmd[2*((1 << l) - 1 + sw) + ((k >> (dist_pkg::NUM_LEVELS - 1 - l)) & 1)];
		end
		return hit;
	endfunction

	// single path from the root down to leaf k
	function automatic logic [dist_pkg::CFG_WIDTH-1:0] path_cmd(int k);
		logic [dist_pkg::CFG_WIDTH-1:0] cmd;
		cmd = '0;
		for (int l = 0; l < dist_pkg::NUM_LEVELS; l++)
		begin
			cmd[2*((1 << l) - 1 + (k >> (dist_pkg::NUM_LEVELS - l)))
				+ ((k >> (dist_pkg::NUM_LEVELS - 1 - l)) & 1)] = 1'b1;
		end
		return cmd;
	endfunction

	function automatic logic busy();
		foreach (inflight[i])
		begin
			if (inflight[i][dist_pkg::CFG_WIDTH+dist_pkg::DATA_WIDTH])
				return 1'b1;
		end
		return 1'b0;
	endfunction

	// leaves at this edge belong to the entry from three edges back
	always @(posedge i_clk or negedge i_rst_n)
	begin
		logic [dist_pkg::CFG_WIDTH+dist_pkg::DATA_WIDTH:0] e;
		logic [dist_pkg::NUM_LEAVES-1:0] exp_v;
		logic [dist_pkg::NUM_LEAVES-1:0][dist_pkg::DATA_WIDTH-1:0] exp_d;
		if (!i_rst_n)
			inflight.delete();
		else
		begin
			if (inflight.size() == dist_pkg::NUM_LEVELS)
			begin
				e = inflight.pop_front();
				for (int k = 0; k < dist_pkg::NUM_LEAVES; k++)
				begin
					exp_v[k] = e[dist_pkg::CFG_WIDTH+dist_pkg::DATA_WIDTH]
						& leaf_hit(e[dist_pkg::DATA_WIDTH +: dist_pkg::CFG_WIDTH], k);
					exp_d[k] = exp_v[k] ? e[dist_pkg::DATA_WIDTH-1:0] : '0;
				end
				checks++;
				assert (o_leaf_valid === exp_v)
				else
				begin
					$display("Mismatch at %0t: leaf valid %b, expected %b",
						$time, o_leaf_valid, exp_v);
					errors++;
				end
				assert (o_leaf_data === exp_d)
				else
				begin
					$display("Mismatch at %0t: leaf data differs, expected valid %b", $time, exp_v);
					errors++;
				end
			end
			inflight.push_back({i_valid & sw_en, sw_cmd, i_data});
		end
	end

	////////////////////////////////////////
	// drivers
	////////////////////////////////////////

	task automatic step();
		@(posedge i_clk);
		#1;
	endtask

	task automatic stop_on_timeout(string what);
		$display("timeout while waiting for %s", what);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	// setup phase, then access phase until pready
	task automatic apb_xfer(input logic wr, input logic [dist_pkg::APB_ADDR_WIDTH-1:0] addr,
		input logic [31:0] wdata, output logic [31:0] rdata, output logic err);
		int n;
		step();
		i_psel = 1'b1;
		i_penable = 1'b0;
		i_pwrite = wr;
		i_paddr = addr;
		i_pwdata = wdata;
		step();
		i_penable = 1'b1;
		n = 0;
		@(posedge i_clk);
		while (!o_pready)
		begin
			n++;
			if (n > max_wait)
				stop_on_timeout("apb pready");
			@(posedge i_clk);
		end
		rdata = o_prdata;
		err = o_pslverr;
		#1;
		i_psel = 1'b0;
		i_penable = 1'b0;
		// register copy follows the write once its access phase is done
		if (wr && addr == dist_pkg::ADDR_CMD)
			sw_cmd = wdata[dist_pkg::CFG_WIDTH-1:0];
		if (wr && addr == dist_pkg::ADDR_CTRL)
			sw_en = wdata[0];
	endtask

	task automatic reg_write(input logic [dist_pkg::APB_ADDR_WIDTH-1:0] addr,
		input logic [31:0] wdata, input logic exp_err);
		logic [31:0] rdata;
		logic err;
		apb_xfer(1'b1, addr, wdata, rdata, err);
		checks++;
		assert (err === exp_err)
		else
		begin
			$display("Mismatch at %0t: pslverr %b on write to %h", $time, err, addr);
			errors++;
		end
	endtask

	task automatic reg_read(input logic [dist_pkg::APB_ADDR_WIDTH-1:0] addr,
		input logic [31:0] exp, input logic exp_err);
		logic [31:0] rdata;
		logic err;
		apb_xfer(1'b0, addr, '0, rdata, err);
		checks++;
		assert (rdata === exp && err === exp_err)
		else
		begin
			$display("Mismatch at %0t: read %h gave %h err %b, expected %h err %b",
				$time, addr, rdata, err, exp, exp_err);
			errors++;
		end
	endtask

	// back to back words, random payload
	task automatic send_words(int n);
		for (int i = 0; i < n; i++)
		begin
			step();
			i_valid = 1'b1;
			i_data = $urandom;
		end
		step();
		i_valid = 1'b0;
		i_data = '0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		step();
		while (busy())
		begin
			n++;
			if (n > max_wait)
				stop_on_timeout("the tree to drain");
			step();
		end
	endtask

	task automatic end_test(string name, int err_before);
		tests++;
		$display("test %0d %s: %0d errors", tests, name, errors - err_before);
	endtask

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////

	initial
	begin
		int err0;
		void'($urandom(32'h33bf64d4));
		i_rst_n = 1'b0;
		i_psel = 1'b0;
		i_penable = 1'b0;
		i_pwrite = 1'b0;
		i_paddr = '0;
		i_pwdata = '0;
		i_valid = 1'b0;
		i_data = '0;
		sw_cmd = '0;
		sw_en = 1'b0;
		errors = 0;
		checks = 0;
		tests = 0;
		repeat (4) @(posedge i_clk);
		#1;
		i_rst_n = 1'b1;

		// reset values, then masked readback; input while disabled goes nowhere
		err0 = errors;
		reg_read(dist_pkg::ADDR_CMD, 32'h0, 1'b0);
		reg_read(dist_pkg::ADDR_CTRL, 32'h0, 1'b0);
		send_words(8);
		reg_write(dist_pkg::ADDR_CMD, 32'hffff_ffff, 1'b0);
		reg_read(dist_pkg::ADDR_CMD, 32'h0000_3fff, 1'b0);
		reg_write(dist_pkg::ADDR_CTRL, 32'hffff_ffff, 1'b0);
		reg_read(dist_pkg::ADDR_CTRL, 32'h1, 1'b0);
		drain();
		end_test("reset and register access", err0);

		// broadcast, one path per leaf, then all off
		err0 = errors;
		send_words(2);
		for (int k = 0; k < dist_pkg::NUM_LEAVES; k++)
		begin
			reg_write(dist_pkg::ADDR_CMD, 32'(path_cmd(k)), 1'b0);
			send_words(2);
		end
		reg_write(dist_pkg::ADDR_CMD, 32'h0, 1'b0);
		send_words(2);
		drain();
		end_test("fixed routing patterns", err0);

		// reprogramming races the stream
		err0 = errors;
		fork
			send_words(200);
			begin
				for (int w = 0; w < 40; w++)
				begin
					reg_write(dist_pkg::ADDR_CMD, $urandom, 1'b0);
					repeat ($urandom_range(1, 4)) @(posedge i_clk);
				end
			end
		join
		drain();
		end_test("random routing", err0);

		err0 = errors;
		reg_write(dist_pkg::ADDR_CMD, 32'h0000_3fff, 1'b0);
		reg_write(dist_pkg::ADDR_CTRL, 32'h0, 1'b0);
		send_words(10);
		drain();
		reg_write(dist_pkg::ADDR_CTRL, 32'h1, 1'b0);
		send_words(10);
		drain();
		end_test("enable gating", err0);

		// holes in the map answer with an error and touch nothing
		// both registers are nonzero here, so a stray zero write shows up
		err0 = errors;
		reg_write(4'h8, 32'h0, 1'b1);
		reg_write(4'hc, 32'h0, 1'b1);
		reg_write(4'h2, 32'h0, 1'b1);
		reg_read(4'hc, 32'h0, 1'b1);
		reg_read(4'h1, 32'h0, 1'b1);
		reg_read(dist_pkg::ADDR_CMD, 32'(sw_cmd), 1'b0);
		reg_read(dist_pkg::ADDR_CTRL, 32'(sw_en), 1'b0);
		end_test("unmapped addresses", err0);

		$display("tests %0d, checks %0d, errors %0d, property failures %0d",
			tests, checks, errors, dut_i.props_i.fail_count);
		if (errors == 0 && dut_i.props_i.fail_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule
